// ==== include/boot_rom_table.svh ====
/*
  Boot ROM contents, sixteen words indexed by the low four word-address
  bits. Included inside the ROM slave and the bus checker, which both
  import soc_bus_pkg for the word type.
*/
localparam bus_data_t BOOT_ROM_TABLE [16] = '{
  16'hfa31,  // cli, then xor
  16'hc08e,
  16'hd08e,  // mov ss
  16'hbc00,
  16'h7c00,  // Stack top
  16'hfbfc,  // sti, cld
  16'hb0f1,
  16'he6f1,
  16'h5bea,  // Reset vector, far jump
  16'h00e0,
  16'h00f0,  // Segment 0xf000
  16'h3036,
  16'h2f30,
  16'h392f,
  16'h3930,
  16'hfc00   // Model byte
};

// ==== hw/soc_bus_pkg.sv ====
/*
  Shared definitions for the CPU-side I/O fabric.
  Holds the bus field types, the default address windows of the local
  slaves and the interrupt vector base. Modules import it in their header.
*/
package soc_bus_pkg;

  // Request address as {io_tag, word address 19:1}
  typedef logic [19:0] bus_addr_t;

  typedef logic [15:0] bus_data_t;  // One bus word
  typedef logic [1:0]  bus_sel_t;   // Byte lanes, bit 0 is the low byte

  // Interrupt lines, index 0 has the highest priority
  typedef logic [7:0]  irq_vec_t;
  typedef logic [2:0]  irq_id_t;    // Number of the line being served

  // Boot ROM, memory 0xfff00 - 0xfffff
  localparam bus_addr_t ROM_BASE  = 20'h7ff80;
  localparam bus_addr_t ROM_MASK  = 20'hfff80;  // Tag bit included

  // LED and switch port, io 0xf100 - 0xf103
  localparam bus_addr_t GPIO_BASE = 20'h87880;
  localparam bus_addr_t GPIO_MASK = 20'h87ffe;

  // Vector returned on acknowledge is this base plus the line number
  localparam bus_data_t IRQ_VECTOR_BASE = 16'h0008;

endpackage

// ==== hw/reset_debounce.sv ====
/*
  Reset stretcher for the external active-low reset.
  Keeps the internal reset asserted while the input is low and for a
  further 2**DEBOUNCE_BITS cycles once it has been released.
*/
`timescale 1ns/10ps

module reset_debounce #(
  parameter int unsigned DEBOUNCE_BITS = 17
) (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_n_o
);

  logic [DEBOUNCE_BITS-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt         <= '1;  // Reload on every low sample
      sys_rst_n_o <= 1'b0;
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      // Released one edge after the count runs out
      sys_rst_n_o <= (cnt == '0);
    end
  end

endmodule

// ==== hw/bus_window_decoder.sv ====
/*
  Address window decoder for the CPU bus.
  Routes the combined cyc/stb strobe to the boot ROM, the GPIO port or
  the built-in default slave, and returns the data and ack of the one
  selected. The default slave answers at once with zero data.
*/
`timescale 1ns/10ps

module bus_window_decoder
  import soc_bus_pkg::*;
#(
  parameter bus_addr_t ROM_BASE  = soc_bus_pkg::ROM_BASE,
  parameter bus_addr_t ROM_MASK  = soc_bus_pkg::ROM_MASK,
  parameter bus_addr_t GPIO_BASE = soc_bus_pkg::GPIO_BASE,
  parameter bus_addr_t GPIO_MASK = soc_bus_pkg::GPIO_MASK
) (
  // Master request
  input  bus_addr_t adr_i,
  input  logic      cyc_i,
  input  logic      stb_i,

  // Slave returns
  input  bus_data_t rom_dat_i,
  input  logic      rom_ack_i,
  input  bus_data_t gpio_dat_i,
  input  logic      gpio_ack_i,

  // Slave strobes
  output logic      rom_stb_o,
  output logic      gpio_stb_o,

  // Back to the master
  output bus_data_t dat_o,
  output logic      ack_o
);

  logic req;
  logic rom_hit;
  logic gpio_hit;
  logic def_hit;
  logic def_stb;

  // Single strobe for the slaves
  assign req = cyc_i & stb_i;

  // Window match, ROM takes precedence if the windows ever overlap
  assign rom_hit  = ((adr_i & ROM_MASK) == ROM_BASE);
  assign gpio_hit = !rom_hit && ((adr_i & GPIO_MASK) == GPIO_BASE);
  assign def_hit  = !rom_hit && !gpio_hit;

  assign rom_stb_o  = req & rom_hit;
  assign gpio_stb_o = req & gpio_hit;
  assign def_stb    = req & def_hit;  // Unmapped memory or io

  // Return path, selected by the same match
  always_comb begin
    if (rom_hit) begin
      dat_o = rom_dat_i;
      ack_o = rom_ack_i;
    end else if (gpio_hit) begin
      dat_o = gpio_dat_i;
      ack_o = gpio_ack_i;
    end else begin
      dat_o = '0;       // Default slave reads as zero
      ack_o = def_stb;  // Same-cycle ack
    end
  end

endmodule

// ==== hw/boot_rom.sv ====
/*
  Read-only boot ROM slave for the top memory window.
  Sixteen words are mirrored across the whole window. Each strobe gets
  a registered one-cycle ack; writes are acked and have no effect.
*/
`timescale 1ns/10ps

module boot_rom
  import soc_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_lck,
  input  logic      stb_i,
  input  bus_addr_t adr_i,
  output bus_data_t dat_o,
  output logic      ack_o
);

  `include "boot_rom_table.svh"

  logic [3:0] word_idx;

  // Upper address bits ignored, so the table repeats
  assign word_idx = adr_i[3:0];

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & !ack_o;  // Drops while the master sees it
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      dat_o <= BOOT_ROM_TABLE[word_idx];
    end
  end

endmodule

// ==== hw/gpio_leds.sv ====
/*
  LED and switch register on the io bus.
  Writes with the low lane selected load the LEDs, the high byte is
  read-only. Reads return the switches over the LEDs, one-cycle ack.
*/
`timescale 1ns/10ps

module gpio_leds
  import soc_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_lck,
  input  logic       stb_i,
  input  logic       we_i,
  input  bus_sel_t   sel_i,
  input  bus_data_t  dat_i,
  input  logic [7:0] sw_i,
  output logic [7:0] leds_o,
  output bus_data_t  dat_o,
  output logic       ack_o
);

  logic access;

  assign access = stb_i & !ack_o;  // First cycle of a strobe

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_o  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_o <= access;
      if (access && we_i && sel_i[0]) begin
        leds_o <= dat_i[7:0];
      end
    end
  end

  // Readback word
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= {sw_i, leds_o};
    end
  end

endmodule

// ==== hw/irq_ctrl.sv ====
/*
  Priority interrupt controller for eight request lines.
  Rising edges are latched as pending; intr_o stays high while any line
  is pending. iid_o names the lowest pending line, and an acknowledge
  pulse clears that line at the end of its cycle.
*/
`timescale 1ns/10ps

module irq_ctrl
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_lck,
  input  irq_vec_t irq_i,
  input  logic     inta_i,
  output logic     intr_o,
  output irq_id_t  iid_o
);

  irq_vec_t irq_q;    // Previous sample for edge detect
  irq_vec_t rise;
  irq_vec_t pend;
  irq_vec_t clr;

  assign rise = irq_i & ~irq_q;

  // Lowest index wins, scanned from the top down
  always_comb begin
    iid_o = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (pend[i]) begin
        iid_o = irq_id_t'(i);
      end
    end
  end

  // Bit served by this acknowledge
  assign clr = inta_i ? (irq_vec_t'(1) << iid_o) : '0;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q <= '0;
      pend  <= '0;
    end else begin
      irq_q <= irq_i;
      pend  <= (pend & ~clr) | rise;  // New edge beats a clear
    end
  end

  assign intr_o = |pend;

endmodule

// ==== hw/io_fabric_top.sv ====
/*
  Top level of the CPU-side I/O fabric.
  Stretches the reset, decodes the bus into the boot ROM, the GPIO port
  and the default slave, and runs the interrupt controller. During an
  acknowledge the interrupt vector replaces the bus read data.
*/
`timescale 1ns/10ps

module io_fabric_top
  import soc_bus_pkg::*;
#(
  parameter int unsigned DEBOUNCE_BITS = 17,
  parameter bus_addr_t   ROM_BASE      = soc_bus_pkg::ROM_BASE,
  parameter bus_addr_t   ROM_MASK      = soc_bus_pkg::ROM_MASK,
  parameter bus_addr_t   GPIO_BASE     = soc_bus_pkg::GPIO_BASE,
  parameter bus_addr_t   GPIO_MASK     = soc_bus_pkg::GPIO_MASK
) (
  input  logic       clk,
  input  logic       rst_lck,

  // Bus master side
  input  bus_addr_t  adr_i,
  input  bus_data_t  dat_i,
  input  bus_sel_t   sel_i,
  input  logic       we_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       inta_i,
  output bus_data_t  dat_o,
  output logic       ack_o,
  output logic       intr_o,

  // Board side
  input  irq_vec_t   irq_i,
  input  logic [7:0] sw_i,
  output logic [7:0] leds_o
);

  logic      sys_rst_n;
  logic      rom_stb;
  logic      rom_ack;
  bus_data_t rom_dat;
  logic      gpio_stb;
  logic      gpio_ack;
  bus_data_t gpio_dat;
  bus_data_t bus_dat;
  irq_id_t   iid;

  reset_debounce #(
    .DEBOUNCE_BITS (DEBOUNCE_BITS)
  ) i_rst (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .sys_rst_n_o (sys_rst_n)
  );

  bus_window_decoder #(
    .ROM_BASE  (ROM_BASE),
    .ROM_MASK  (ROM_MASK),
    .GPIO_BASE (GPIO_BASE),
    .GPIO_MASK (GPIO_MASK)
  ) i_dec (
    .adr_i      (adr_i),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .rom_dat_i  (rom_dat),
    .rom_ack_i  (rom_ack),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack),
    .rom_stb_o  (rom_stb),
    .gpio_stb_o (gpio_stb),
    .dat_o      (bus_dat),
    .ack_o      (ack_o)
  );

  boot_rom i_rom (
    .clk     (clk),
    .rst_lck (sys_rst_n),
    .stb_i   (rom_stb),
    .adr_i   (adr_i),
    .dat_o   (rom_dat),
    .ack_o   (rom_ack)
  );

  gpio_leds i_gpio (
    .clk     (clk),
    .rst_lck (sys_rst_n),
    .stb_i   (gpio_stb),
    .we_i    (we_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .sw_i    (sw_i),
    .leds_o  (leds_o),
    .dat_o   (gpio_dat),
    .ack_o   (gpio_ack)
  );

  irq_ctrl i_pic (
    .clk     (clk),
    .rst_lck (sys_rst_n),
    .irq_i   (irq_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  // Vector overrides bus data for the acknowledge cycle
  assign dat_o = inta_i ? (IRQ_VECTOR_BASE + bus_data_t'(iid)) : bus_dat;

endmodule

// ==== verif/io_fabric_assert.sv ====
/*
  Concurrent assertions on the I/O fabric top level.
  Bound into io_fabric_top, so they see the internal reset and the slave
  strobes next to the master-side ports.
*/
`timescale 1ns/10ps

module io_fabric_assert
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_lck,     // Internal reset of the fabric
  input  logic     ack_i,
  input  logic     rom_stb_i,
  input  logic     gpio_stb_i,
  input  logic     intr_i,
  input  irq_vec_t irq_i
);

  logic irq_seen;      // Some line went high since reset
  int   fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_seen <= 1'b0;
    end else if (|irq_i) begin
      irq_seen <= 1'b1;
    end
  end

  // Registered slaves give a single-cycle ack
  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    (ack_i && (rom_stb_i || gpio_stb_i)) |=> !ack_i)
    else begin
      $error("ack_o high on two consecutive edges for one slave strobe");
      fail_cnt++;
    end

  ack_quiet_in_reset: assert property (@(posedge clk) !rst_lck |-> !ack_i)
    else begin
      $error("ack_o high while the fabric is in reset");
      fail_cnt++;
    end

  intr_needs_edge: assert property (@(posedge clk) disable iff (!rst_lck)
    !irq_seen |-> !intr_i)
    else begin
      $error("intr_o high with no interrupt line raised since reset");
      fail_cnt++;
    end

endmodule

bind io_fabric_top io_fabric_assert i_assert (
  .clk        (clk),
  .rst_lck    (sys_rst_n),
  .ack_i      (ack_o),
  .rom_stb_i  (rom_stb),
  .gpio_stb_i (gpio_stb),
  .intr_i     (intr_o),
  .irq_i      (irq_i)
);

// ==== verif/bus_checker.sv ====
/*
  Response checker for the I/O fabric testbench.
  Watches the DUT ports at each rising edge and compares every bus ack
  and every interrupt acknowledge with the expected values of the entry
  that the testbench is applying. Prints one line per finished test.
*/
`timescale 1ns/10ps

module bus_checker
  import soc_bus_pkg::*;
(
  input  logic       clk,
  // DUT ports
  input  bus_addr_t  adr_i,
  input  logic       cyc_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic       inta_i,
  input  bus_data_t  bus_dat_i,
  input  logic       ack_i,
  input  logic       intr_i,
  input  logic [7:0] leds_i,
  // Running entry
  input  logic       active_i,
  input  logic [1:0] kind_i,
  input  int         test_no_i,
  input  bus_data_t  exp_dat_i,
  input  logic [7:0] exp_leds_i,
  input  logic       exp_lat_i,   // Edges with strobe before the ack
  input  logic       exp_intr_i,  // intr_o after the acknowledge
  input  logic       rom_i,       // Read data comes from the ROM table
  output int         err_cnt_o,
  output int         test_cnt_o
);

  `include "boot_rom_table.svh"

  localparam logic [1:0] K_IDLE = 2'd0;

  int        wait_cnt;
  logic      inta_q;
  logic      bad;
  bus_data_t exp_rd;

  // Table word for the low four word-address bits
  assign exp_rd = rom_i ? BOOT_ROM_TABLE[adr_i[3:0]] : exp_dat_i;

  initial begin
    err_cnt_o  = 0;
    test_cnt_o = 0;
    wait_cnt   = 0;
    inta_q     = 1'b0;
    bad        = 1'b0;
  end

  task automatic mismatch(input string what, input logic [15:0] got, input logic [15:0] exp);
    $display("** Error at %0t: test %0d, %s is %h, expected %h",
             $time, test_no_i, what, got, exp);
    bad = 1'b1;
  endtask

  task automatic close_test();
    test_cnt_o++;
    if (bad) begin
      err_cnt_o++;
      $display("Test %0d kind %0d: mismatches found", test_no_i, kind_i);
    end else begin
      $display("Test %0d kind %0d: ok", test_no_i, kind_i);
    end
    bad = 1'b0;
  endtask

  always @(posedge clk) begin
    if (active_i && kind_i == K_IDLE) begin  // State right after reset
      if (ack_i !== 1'b0) mismatch("ack_o", 16'(ack_i), 16'h0);
      if (intr_i !== 1'b0) mismatch("intr_o", 16'(intr_i), 16'h0);
      if (leds_i !== 8'h00) mismatch("leds_o", 16'(leds_i), 16'h0);
      close_test();
    end
    if (cyc_i && stb_i && !ack_i) begin
      wait_cnt++;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt != int'(exp_lat_i)) mismatch("ack delay", 16'(wait_cnt), 16'(exp_lat_i));
      if (!we_i && bus_dat_i !== exp_rd) mismatch("read data", bus_dat_i, exp_rd);
      if (leds_i !== exp_leds_i) mismatch("leds_o", 16'(leds_i), 16'(exp_leds_i));
      close_test();
      wait_cnt = 0;
    end
    // Pending bit has cleared one edge after the acknowledge
    if (inta_q) begin
      if (intr_i !== exp_intr_i) mismatch("intr_o", 16'(intr_i), 16'(exp_intr_i));
      close_test();
    end
    if (inta_i && bus_dat_i !== exp_dat_i) mismatch("vector", bus_dat_i, exp_dat_i);
    inta_q = inta_i;
  end

endmodule

// ==== verif/tb_io_fabric.sv ====
/*
  Testbench for the I/O fabric top level.
  Builds a table of bus reads, bus writes and interrupt acknowledges,
  applies it in a loop after reset and leaves the comparing to
  bus_checker. A cycle counter stops a hung run.
*/
`timescale 1ns/10ps

module tb_io_fabric
  import soc_bus_pkg::*;
();

  localparam int  DEB_BITS = 4;
  localparam time DRV      = 5ns;  // Input delay after the rising edge
  localparam logic [1:0] K_IDLE = 2'd0, K_READ = 2'd1, K_WRITE = 2'd2, K_IRQ = 2'd3;

  typedef struct packed {
    logic [1:0] kind;
    bus_addr_t  adr;
    bus_data_t  wdat;
    bus_sel_t   sel;
    bus_data_t  exp_dat;
    logic [7:0] exp_leds;
    logic       lat;
    logic       exp_intr;
    logic       rom;
  } entry_t;

  logic clk, rst_lck, we_i, cyc_i, stb_i, inta_i, ack_o, intr_o;
  bus_addr_t  adr_i;
  bus_data_t  dat_i, dat_o, wdat;
  bus_sel_t   sel_i;
  irq_vec_t   irq_i;
  logic [7:0] sw_i, leds_o, led_model;
  entry_t     tbl[$];
  entry_t     cur;
  logic       active;
  int         test_no, err_cnt, test_cnt, cycles;
  int         assert_fails;
  int         cycle_limit = 10000;

  io_fabric_top #(.DEBOUNCE_BITS(DEB_BITS)) i_dut (
    .clk(clk), .rst_lck(rst_lck), .adr_i(adr_i), .dat_i(dat_i), .sel_i(sel_i),
    .we_i(we_i), .cyc_i(cyc_i), .stb_i(stb_i), .inta_i(inta_i), .dat_o(dat_o),
    .ack_o(ack_o), .intr_o(intr_o), .irq_i(irq_i), .sw_i(sw_i), .leds_o(leds_o)
  );

  bus_checker i_chk (
    .clk(clk), .adr_i(adr_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .inta_i(inta_i), .bus_dat_i(dat_o), .ack_i(ack_o), .intr_i(intr_o),
    .leds_i(leds_o), .active_i(active), .kind_i(cur.kind), .test_no_i(test_no),
    .exp_dat_i(cur.exp_dat), .exp_leds_i(cur.exp_leds), .exp_lat_i(cur.lat),
    .exp_intr_i(cur.exp_intr), .rom_i(cur.rom), .err_cnt_o(err_cnt),
    .test_cnt_o(test_cnt)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a bus or interrupt handshake hung", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic push_entry(input logic [1:0] kind, input bus_addr_t adr, input bus_data_t wd,
                            input bus_data_t exp, input logic lat, input logic rom,
                            input logic intr);
    entry_t e;
    e = '{kind, adr, wd, 2'b11, exp, led_model, lat, intr, rom};
    tbl.push_back(e);
  endtask

  task automatic push_write(input bus_addr_t adr, input bus_sel_t sel, input bus_data_t wd);
    if (adr[19] && sel[0]) begin
      led_model = wd[7:0];  // Only the GPIO low lane is writable
    end
    push_entry(K_WRITE, adr, wd, 16'h0, 1'b1, 1'b0, 1'b0);
    tbl[tbl.size()-1].sel = sel;
  endtask

  task automatic apply_entry();
    active = 1'b1;
    if (cur.kind == K_IRQ) begin
      irq_i = irq_i | cur.wdat[7:0];
      @(posedge clk);
      while (!intr_o) begin
        @(posedge clk);
      end
      #DRV;
      inta_i = 1'b1;
      @(posedge clk);
      #DRV;
      inta_i = 1'b0;
      @(posedge clk);  // Checker looks at intr_o here
    end else if (cur.kind != K_IDLE) begin
      adr_i = cur.adr;
      dat_i = cur.wdat;
      sel_i = cur.sel;
      we_i  = (cur.kind == K_WRITE);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      @(posedge clk);
      while (!ack_o) begin
        @(posedge clk);
      end
    end else begin
      @(posedge clk);
    end
    #DRV;
    {cyc_i, stb_i, we_i, active} = '0;
  endtask

  initial begin
    clk       = 1'b0;
    rst_lck   = 1'b0;
    adr_i     = '0;
    dat_i     = '0;
    sel_i     = '0;
    {we_i, cyc_i, stb_i, inta_i, active} = '0;
    irq_i     = '0;
    cur       = '0;
    test_no   = 0;
    cycles    = 0;
    led_model = '0;
    void'($urandom(32'h36c4));
    sw_i = 8'($urandom);

    push_entry(K_IDLE, 20'h0, 16'h0, 16'h0, 1'b0, 1'b0, 1'b0);
    push_entry(K_READ, 20'h7ff80, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);
    push_entry(K_READ, 20'h7ff85, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);
    push_entry(K_READ, 20'h7ffff, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);
    push_entry(K_READ, 20'h7ffa5, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);  // Mirror of 5
    push_entry(K_READ, 20'h7ffc8, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);
    push_write(20'h7ff83, 2'b11, bus_data_t'($urandom));            // ROM ignores it
    push_entry(K_READ, 20'h7ff83, 16'h0, 16'h0, 1'b1, 1'b1, 1'b0);
    push_write(20'h87880, 2'b01, bus_data_t'($urandom));
    push_entry(K_READ, 20'h87880, 16'h0, {sw_i, led_model}, 1'b1, 1'b0, 1'b0);
    wdat = {8'($urandom), ~led_model};
    push_write(20'h87881, 2'b10, wdat);                             // No low lane
    push_entry(K_READ, 20'h87881, 16'h0, {sw_i, led_model}, 1'b1, 1'b0, 1'b0);
    push_write(20'h87880, 2'b11, bus_data_t'($urandom));
    push_entry(K_READ, 20'h87880, 16'h0, {sw_i, led_model}, 1'b1, 1'b0, 1'b0);
    push_entry(K_READ, 20'h80040, 16'h0, 16'h0, 1'b0, 1'b0, 1'b0);  // Unmapped io
    push_entry(K_READ, 20'h01234, 16'h0, 16'h0, 1'b0, 1'b0, 1'b0);  // Unmapped memory
    push_entry(K_IRQ, 20'h0, 16'h0024, 16'h000a, 1'b0, 1'b0, 1'b1);
    push_entry(K_IRQ, 20'h0, 16'h0024, 16'h000d, 1'b0, 1'b0, 1'b0);
    cycle_limit = 2 + 2 * (2 ** DEB_BITS) + 8 + tbl.size() * 10 + 10;

    repeat (2) @(posedge clk);
    #DRV;
    rst_lck = 1'b1;
    repeat (2 * (2 ** DEB_BITS) + 8) @(posedge clk);  // Well past the debounce

    foreach (tbl[n]) begin
      @(posedge clk);
      #DRV;
      cur     = tbl[n];
      test_no = n + 1;
      apply_entry();
    end
    repeat (2) @(posedge clk);

    assert_fails = i_dut.i_assert.fail_cnt;
    if (test_cnt != tbl.size()) begin
      $display("Some tests never produced a response");
    end
    if (assert_fails != 0) begin
      $display("Some assertions on the DUT failed during the run");
    end
    $display("Summary: %0d of %0d tests reported, %0d with errors, %0d assertion failures",
             test_cnt, tbl.size(), err_cnt, assert_fails);
    if (err_cnt == 0 && test_cnt == tbl.size() && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
hw/soc_bus_pkg.sv
hw/reset_debounce.sv
hw/bus_window_decoder.sv
hw/boot_rom.sv
hw/gpio_leds.sv
hw/irq_ctrl.sv
hw/io_fabric_top.sv
verif/io_fabric_assert.sv
verif/bus_checker.sv
verif/tb_io_fabric.sv
